/* Makefile */
TOOL       = verilator
TOP        = tb_cache_subsystem
FLIST      = flist.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* backing_memory.sv */
// word memory behind the caches with a fixed read latency
// the load port writes one word per cycle, used before the caches run

`timescale 1ns/1ps

module backing_memory #(
    parameter int mem_latency = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            read,
    input  cache_pkg::mem_req_t             addr,
    input  logic                            load_valid,
    input  cache_pkg::mem_load_t            load,
    output logic                            rdata_valid,
    output logic [cache_pkg::data_bits-1:0] rdata
);

    localparam int word_num = 1 << cache_pkg::addr_bits;

    logic [cache_pkg::data_bits-1:0] mem [word_num];
    logic [cache_pkg::data_bits-1:0] data_pipe [mem_latency];
    logic [mem_latency-1:0]          valid_pipe;

    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load.addr] <= load.data;
        end
        data_pipe[0] <= mem[addr.addr];
        for (int i = 1; i < mem_latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // read strobe walks alongside the data
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= read;
            for (int i = 1; i < mem_latency; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign rdata_valid = valid_pipe[mem_latency-1];
    assign rdata       = data_pipe[mem_latency-1];

endmodule

/* cache_pkg.sv */
// shared widths and bus structs for the two-port read-only cache
// address fields are sized here, way count and memory latency are
// module parameters set at the top level

package cache_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int set_bits  = 4;
    localparam int tag_bits  = 6;
    localparam int addr_bits = tag_bits + set_bits;
    localparam int data_bits = 32;

    // ------------------------------
    // structs
    // ------------------------------

    // word address, tag in the upper bits
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [set_bits-1:0] set;
    } cache_addr_t;

    typedef struct packed {
        cache_addr_t addr;
    } cache_req_t;

    // hit low marks a response served from memory
    typedef struct packed {
        logic [data_bits-1:0] data;
        logic                 hit;
    } cache_resp_t;

    typedef struct packed {
        cache_addr_t addr;
    } mem_req_t;

    // preload word for the backing memory
    typedef struct packed {
        cache_addr_t          addr;
        logic [data_bits-1:0] data;
    } mem_load_t;

endpackage

/* cache_port.sv */
// one read-only cache port: tag unit, line data RAM and miss fill
// hits respond three cycles after acceptance; a miss at the tag output
// stalls the tag pipeline until the fill data comes back from memory

`timescale 1ns/1ps

module cache_port #(
    parameter int way_num = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            req_valid,
    input  cache_pkg::cache_req_t           req,
    output logic                            busy,
    input  logic                            clear_start,
    output logic                            clear_busy,
    output logic                            resp_valid,
    output cache_pkg::cache_resp_t          resp,
    output logic                            miss_req,
    output cache_pkg::mem_req_t             miss_addr,
    input  logic                            grant,
    input  logic                            rdata_valid,
    input  logic [cache_pkg::data_bits-1:0] rdata
);

    localparam int way_bits = $clog2(way_num);
    localparam int set_num  = 1 << cache_pkg::set_bits;

    typedef enum logic [1:0] {
        fill_idle,
        fill_request,
        fill_wait
    } fill_state_t;

    fill_state_t                    state;
    logic                           cke;
    logic                           fill_done;
    logic                           tag_valid;
    logic                           tag_hit;
    logic [way_bits-1:0]            tag_way;
    logic [cache_pkg::set_bits-1:0] tag_set;
    logic [cache_pkg::tag_bits-1:0] tag_d1;
    logic [cache_pkg::tag_bits-1:0] tag_d2;
    logic [cache_pkg::data_bits-1:0] data_ram [set_num][way_num];

    // stall while a miss sits at the tag output, release on fill
    assign fill_done = (state == fill_wait) && rdata_valid;
    assign cke       = !(tag_valid && !tag_hit) || fill_done;
    assign busy      = !cke || clear_busy;
    assign miss_req  = (state == fill_request);

    cache_tag_lru #(
        .way_num (way_num)
    ) u_tag (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .clear_start (clear_start),
        .clear_busy  (clear_busy),
        .s_valid     (req_valid && !busy),
        .s_set       (req.addr.set),
        .s_tag       (req.addr.tag),
        .m_valid     (tag_valid),
        .m_hit       (tag_hit),
        .m_way       (tag_way),
        .m_set       (tag_set)
    );

    // tag follows the tag unit pipeline for the miss address
    always_ff @(posedge clk) begin
        if (cke) begin
            tag_d1 <= req.addr.tag;
            tag_d2 <= tag_d1;
        end
    end

    // ------------------------------
    // miss FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fill_idle;
        end else begin
            case (state)
                fill_idle: begin
                    if (tag_valid && !tag_hit) begin
                        state <= fill_request;
                    end
                end
                fill_request: begin
                    if (grant) begin
                        state <= fill_wait;
                    end
                end
                fill_wait: begin
                    if (rdata_valid) begin
                        state <= fill_idle;
                    end
                end
                default: state <= fill_idle;
            endcase
        end
    end

    // held while requesting and waiting
    always_ff @(posedge clk) begin
        if (state == fill_idle) begin
            miss_addr.addr.tag <= tag_d2;
            miss_addr.addr.set <= tag_set;
        end
    end

    // ------------------------------
    // data RAM and response
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= (tag_valid && tag_hit) || fill_done;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_ram[tag_set][tag_way] <= rdata;
            resp.data                  <= rdata;
            resp.hit                   <= 1'b0;
        end else begin
            resp.data <= data_ram[tag_set][tag_way];
            resp.hit  <= 1'b1;
        end
    end

    a_no_resp_in_wait: assert property (@(posedge clk) disable iff (reset)
        (state == fill_wait) |-> !resp_valid);

endmodule

/* cache_subsystem.sv */
// two-port read-only cache subsystem
// both ports share one backing memory through a round-robin arbiter;
// the memory is preloaded through the load port while the caches idle

`timescale 1ns/1ps

module cache_subsystem #(
    parameter int way_num     = 4,
    parameter int mem_latency = 3
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [1:0]                    req_valid,
    input  cache_pkg::cache_req_t [1:0]   req,
    output logic [1:0]                    busy,
    output logic [1:0]                    resp_valid,
    output cache_pkg::cache_resp_t [1:0]  resp,
    input  logic [1:0]                    clear_start,
    output logic [1:0]                    clear_busy,
    input  logic                          load_valid,
    input  cache_pkg::mem_load_t          load
);

    logic [1:0]                      miss_req;
    cache_pkg::mem_req_t [1:0]       miss_addr;
    logic [1:0]                      grant;
    logic [1:0]                      port_rdata_valid;
    logic [cache_pkg::data_bits-1:0] port_rdata;
    logic                            mem_read;
    cache_pkg::mem_req_t             mem_addr;
    logic                            mem_rdata_valid;
    logic [cache_pkg::data_bits-1:0] mem_rdata;

    for (genvar p = 0; p < 2; p++) begin : g_port
        cache_port #(
            .way_num (way_num)
        ) u_port (
            .clk         (clk),
            .reset       (reset),
            .req_valid   (req_valid[p]),
            .req         (req[p]),
            .busy        (busy[p]),
            .clear_start (clear_start[p]),
            .clear_busy  (clear_busy[p]),
            .resp_valid  (resp_valid[p]),
            .resp        (resp[p]),
            .miss_req    (miss_req[p]),
            .miss_addr   (miss_addr[p]),
            .grant       (grant[p]),
            .rdata_valid (port_rdata_valid[p]),
            .rdata       (port_rdata)
        );
    end

    mem_arbiter u_arbiter (
        .clk             (clk),
        .reset           (reset),
        .miss_req        (miss_req),
        .miss_addr       (miss_addr),
        .grant           (grant),
        .mem_read        (mem_read),
        .mem_addr        (mem_addr),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rdata       (mem_rdata),
        .rdata_valid     (port_rdata_valid),
        .rdata           (port_rdata)
    );

    backing_memory #(
        .mem_latency (mem_latency)
    ) u_memory (
        .clk         (clk),
        .reset       (reset),
        .read        (mem_read),
        .addr        (mem_addr),
        .load_valid  (load_valid),
        .load        (load),
        .rdata_valid (mem_rdata_valid),
        .rdata       (mem_rdata)
    );

endmodule

/* cache_tag_lru.sv */
// set-associative tag store with true-LRU ordering per set
// each set holds a most-recent-first list of ways, read in stage 0 and
// written back in stage 2; results appear two cycles after the request
// cke low freezes the whole pipeline, clear_start or reset runs a sweep

`timescale 1ns/1ps

module cache_tag_lru #(
    parameter int way_num = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cke,
    input  logic                           clear_start,
    output logic                           clear_busy,
    input  logic                           s_valid,
    input  logic [cache_pkg::set_bits-1:0] s_set,
    input  logic [cache_pkg::tag_bits-1:0] s_tag,
    output logic                           m_valid,
    output logic                           m_hit,
    output logic [$clog2(way_num)-1:0]     m_way,
    output logic [cache_pkg::set_bits-1:0] m_set
);

    localparam int way_bits = $clog2(way_num);
    localparam int set_num  = 1 << cache_pkg::set_bits;

    typedef struct packed {
        logic                           valid;
        logic [way_bits-1:0]            way;
        logic [cache_pkg::tag_bits-1:0] tag;
    } lru_entry_t;

    // entry 0 is the most recently used
    typedef lru_entry_t [way_num-1:0] lru_list_t;

    lru_list_t                      lru_mem [set_num];
    lru_list_t                      init_list;

    logic                           clear_act;
    logic [cache_pkg::set_bits-1:0] clear_cnt;

    logic                           st1_valid;
    logic                           fw_st2;
    logic                           fw_st3;
    logic [cache_pkg::set_bits-1:0] st1_set;
    logic [cache_pkg::tag_bits-1:0] st1_tag;
    lru_list_t                      st1_dout;
    lru_list_t                      st1_list;
    lru_list_t                      st1_next;
    logic                           st1_hit;
    logic [way_bits-1:0]            st1_pos;

    logic                           st2_valid;
    logic [cache_pkg::set_bits-1:0] st2_set;
    logic                           st2_hit;
    lru_list_t                      st2_list;
    lru_list_t                      st3_list;

    // empty list, last entry is the first victim
    always_comb begin
        for (int j = 0; j < way_num; j++) begin
            init_list[j].valid = 1'b0;
            init_list[j].way   = way_bits'(way_num - 1 - j);
            init_list[j].tag   = '0;
        end
    end

    // ------------------------------
    // stage 1: forward, compare, reorder
    // ------------------------------
    always_comb begin
        st1_list = st1_dout;
        if (fw_st3) begin
            st1_list = st3_list;
        end
        if (fw_st2) begin
            st1_list = st2_list;
        end
    end

    always_comb begin
        st1_hit = 1'b0;
        st1_pos = way_bits'(way_num - 1);
        for (int j = 0; j < way_num; j++) begin
            if (st1_list[j].valid && (st1_list[j].tag == st1_tag)) begin
                st1_hit = 1'b1;
                st1_pos = way_bits'(j);
            end
        end
    end

    // move to front, entries above the hit slide down one
    always_comb begin
        st1_next = st1_list;
        for (int j = 1; j < way_num; j++) begin
            if (way_bits'(j) <= st1_pos) begin
                st1_next[j] = st1_list[j-1];
            end
        end
        st1_next[0].valid = 1'b1;
        st1_next[0].way   = st1_list[st1_pos].way;
        st1_next[0].tag   = st1_tag;
    end

    // ------------------------------
    // pipeline registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
            fw_st2    <= 1'b0;
            fw_st3    <= 1'b0;
            st2_valid <= 1'b0;
        end else if (cke) begin
            st1_valid <= s_valid;
            fw_st2    <= s_valid && st1_valid && (s_set == st1_set);
            fw_st3    <= s_valid && st2_valid && (s_set == st2_set);
            st2_valid <= st1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            st1_set  <= s_set;
            st1_tag  <= s_tag;
            st2_set  <= st1_set;
            st2_hit  <= st1_hit;
            st2_list <= st1_next;
            st3_list <= st2_list;
        end
    end

    // list memory, sweep wins over the stage 2 write
    always_ff @(posedge clk) begin
        if (cke) begin
            st1_dout <= lru_mem[s_set];
        end
        if (clear_act) begin
            lru_mem[clear_cnt] <= init_list;
        end else if (cke && st2_valid) begin
            lru_mem[st2_set] <= st2_list;
        end
    end

    // one set per cycle
    always_ff @(posedge clk) begin
        if (reset || clear_start) begin
            clear_act <= 1'b1;
            clear_cnt <= '0;
        end else if (clear_act) begin
            clear_cnt <= clear_cnt + 1'b1;
            if (clear_cnt == '1) begin
                clear_act <= 1'b0;
            end
        end
    end

    assign clear_busy = clear_act;
    assign m_valid    = st2_valid;
    assign m_hit      = st2_hit;
    assign m_way      = st2_list[0].way;
    assign m_set      = st2_set;

    a_no_req_in_clear: assert property (@(posedge clk) disable iff (reset)
        !(s_valid && clear_busy));

    a_way_range: assert property (@(posedge clk) disable iff (reset)
        m_valid |-> (m_way < way_num));

endmodule

/* flist.f */
cache_pkg.sv
cache_tag_lru.sv
cache_port.sv
mem_arbiter.sv
backing_memory.sv
cache_subsystem.sv
tb_cache_subsystem.sv

/* mem_arbiter.sv */
// round-robin arbiter sharing the backing memory between two ports
// only one read is outstanding; returned data goes to the granted port

`timescale 1ns/1ps

module mem_arbiter (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [1:0]                        miss_req,
    input  cache_pkg::mem_req_t [1:0]         miss_addr,
    output logic [1:0]                        grant,
    output logic                              mem_read,
    output cache_pkg::mem_req_t               mem_addr,
    input  logic                              mem_rdata_valid,
    input  logic [cache_pkg::data_bits-1:0]   mem_rdata,
    output logic [1:0]                        rdata_valid,
    output logic [cache_pkg::data_bits-1:0]   rdata
);

    logic prio;
    logic pick;
    logic owner;
    logic outstanding;
    logic can_grant;

    // preferred port first, else the other one
    assign pick      = miss_req[prio] ? prio : !prio;
    assign can_grant = (!outstanding || mem_rdata_valid) && (|miss_req);

    always_ff @(posedge clk) begin
        if (reset) begin
            grant       <= 2'b00;
            mem_read    <= 1'b0;
            outstanding <= 1'b0;
            prio        <= 1'b0;
            owner       <= 1'b0;
        end else begin
            grant    <= 2'b00;
            mem_read <= 1'b0;
            if (mem_rdata_valid) begin
                outstanding <= 1'b0;
            end
            if (can_grant) begin
                grant[pick] <= 1'b1;
                mem_read    <= 1'b1;
                outstanding <= 1'b1;
                owner       <= pick;
                prio        <= !pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_grant) begin
            mem_addr <= miss_addr[pick];
        end
    end

    assign rdata_valid = {mem_rdata_valid && owner, mem_rdata_valid && !owner};
    assign rdata       = mem_rdata;

endmodule

/* tb_cache_subsystem.sv */
// testbench for the two-port read-only cache subsystem
// preloads the backing memory through the load port, then drives random
// traffic on both ports and checks data, hit flags, hit latency and clear
// against a memory copy and a per-port LRU model

`timescale 1ns/1ps

module tb_cache_subsystem;

    localparam int way_num     = 4;
    localparam int mem_latency = 3;
    localparam int set_num     = 1 << cache_pkg::set_bits;
    localparam int word_num    = 1 << cache_pkg::addr_bits;
    localparam int hit_latency = 3;
    localparam int wait_limit  = 2000;

    // expected response and issue cycle of one request
    typedef struct packed {
        logic [cache_pkg::data_bits-1:0] data;
        logic                            hit;
        logic [31:0]                     cyc;
        logic                            timed;
    } expect_t;

    logic                         clk;
    logic                         reset;
    logic [1:0]                   req_valid;
    cache_pkg::cache_req_t [1:0]  req;
    logic [1:0]                   busy;
    logic [1:0]                   resp_valid;
    cache_pkg::cache_resp_t [1:0] resp;
    logic [1:0]                   clear_start;
    logic [1:0]                   clear_busy;
    logic                         load_valid;
    cache_pkg::mem_load_t         load;

    logic [cache_pkg::data_bits-1:0] mem_model [word_num];
    logic [cache_pkg::tag_bits-1:0]  lru_tag [2][set_num][way_num];
    int                              lru_len [2][set_num];
    expect_t                         exp_q [2][$];

    int cyc;
    int errors;
    int checks;
    int errors_mark;
    int checks_mark;

    cache_subsystem #(
        .way_num     (way_num),
        .mem_latency (mem_latency)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .clear_start (clear_start),
        .clear_busy  (clear_busy),
        .load_valid  (load_valid),
        .load        (load)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // model
    // ------------------------------

    // move to front on every lookup and drop the oldest tag of a full set
    function automatic logic model_lookup(input int p, input cache_pkg::cache_addr_t a);
        int   pos;
        logic hit;
        pos = -1;
        for (int j = 0; j < lru_len[p][a.set]; j++) begin
            if (lru_tag[p][a.set][j] == a.tag) begin
                pos = j;
            end
        end
        hit = (pos >= 0);
        if (!hit) begin
            if (lru_len[p][a.set] < way_num) begin
                lru_len[p][a.set]++;
            end
            pos = lru_len[p][a.set] - 1;
        end
        for (int j = pos; j > 0; j--) begin
            lru_tag[p][a.set][j] = lru_tag[p][a.set][j-1];
        end
        lru_tag[p][a.set][0] = a.tag;
        return hit;
    endfunction

    function automatic cache_pkg::cache_addr_t rand_addr(input int tag_range);
        cache_pkg::cache_addr_t a;
        a.tag = cache_pkg::tag_bits'($urandom_range(tag_range - 1));
        a.set = cache_pkg::set_bits'($urandom_range(set_num - 1));
        return a;
    endfunction

    task automatic push_expect(input int p, input cache_pkg::cache_addr_t a, input logic timed);
        expect_t e;
        e.data  = mem_model[a];
        e.hit   = model_lookup(p, a);
        e.cyc   = cyc;
        e.timed = timed && e.hit;
        exp_q[p].push_back(e);
    endtask

    task automatic check_resp(input int p);
        expect_t e;
        int      lat;
        if (exp_q[p].size() == 0) begin
            $display("port %0d responded with no request outstanding", p);
            errors++;
        end else begin
            e   = exp_q[p].pop_front();
            lat = cyc - int'(e.cyc);
            checks++;
            if (resp[p].data !== e.data) begin
                $display("mismatch resp[%0d].data: expected %h, got %h", p, e.data, resp[p].data);
                errors++;
            end
            if (resp[p].hit !== e.hit) begin
                $display("mismatch resp[%0d].hit: expected %h, got %h", p, e.hit, resp[p].hit);
                errors++;
            end
            if (e.timed && (lat != hit_latency)) begin
                $display("mismatch resp_valid[%0d] latency: expected %h, got %h",
                         p, hit_latency, lat);
                errors++;
            end
        end
    endtask

    // ------------------------------
    // stimulus helpers
    // ------------------------------

    // inputs change and responses are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        cyc++;
        if (!reset) begin
            for (int p = 0; p < 2; p++) begin
                if (resp_valid[p] === 1'b1) begin
                    check_resp(p);
                end
            end
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("responses checked %0d, errors %0d", checks, errors);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic send_one(input int p, input cache_pkg::cache_addr_t a, input logic timed);
        int n;
        n = 0;
        while (busy[p]) begin
            if (n == wait_limit) begin
                abort_run($sformatf("port %0d stayed busy past the timeout", p));
            end
            next_cycle();
            n++;
        end
        req_valid[p] = 1'b1;
        req[p].addr  = a;
        push_expect(p, a, timed);
        next_cycle();
        req_valid[p] = 1'b0;
    endtask

    // each port sends as soon as its busy drops
    task automatic send_pair(input cache_pkg::cache_addr_t a0, input cache_pkg::cache_addr_t a1);
        cache_pkg::cache_addr_t a [2];
        logic [1:0]             done;
        int                     n;
        a[0] = a0;
        a[1] = a1;
        done = 2'b00;
        n    = 0;
        while (done != 2'b11) begin
            if (n == wait_limit) begin
                abort_run("a pair of requests was not accepted before the timeout");
            end
            for (int p = 0; p < 2; p++) begin
                if (!done[p] && !busy[p]) begin
                    req_valid[p] = 1'b1;
                    req[p].addr  = a[p];
                    push_expect(p, a[p], 1'b0);
                    done[p] = 1'b1;
                end
            end
            next_cycle();
            req_valid = 2'b00;
            n++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || busy != 2'b00) begin
            if (n == wait_limit) begin
                abort_run("responses did not arrive before the timeout");
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s done: %0d responses, %0d errors",
                 name, checks - checks_mark, errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    // ------------------------------
    // tests
    // ------------------------------

    task automatic data_test();
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 80; i++) begin
                send_one(p, rand_addr(8), 1'b0);
            end
        end
        wait_idle();
        report_test("data");
    endtask

    task automatic lru_test();
        cache_pkg::cache_addr_t a;
        int                     s;
        s = int'($urandom_range(set_num - 1));
        // one more distinct tag than ways and then the first again
        for (int i = 0; i <= way_num; i++) begin
            a.set = cache_pkg::set_bits'(s);
            a.tag = cache_pkg::tag_bits'(40 + i);
            send_one(1, a, 1'b0);
        end
        a.tag = cache_pkg::tag_bits'(40);
        send_one(1, a, 1'b0);
        for (int i = 0; i < 60; i++) begin
            a.set = cache_pkg::set_bits'(s + int'($urandom_range(2)));
            a.tag = cache_pkg::tag_bits'(40 + int'($urandom_range(5)));
            send_one(1, a, 1'b0);
        end
        wait_idle();
        report_test("lru");
    endtask

    task automatic hit_latency_test();
        cache_pkg::cache_addr_t warm [8];
        int                     idx;
        // four tags fill set 9 and one tag goes to each of sets 10 to 13
        for (int i = 0; i < 8; i++) begin
            warm[i].set = cache_pkg::set_bits'((i < 4) ? 9 : i + 6);
            warm[i].tag = cache_pkg::tag_bits'((i < 4) ? 20 + i : 30);
            send_one(0, warm[i], 1'b0);
        end
        wait_idle();
        for (int k = 0; k < 24; k++) begin
            idx = int'($urandom_range(7));
            if (busy[0]) begin
                $display("port 0 stalled during a run of hits");
                errors++;
            end
            send_one(0, warm[idx], 1'b1);
        end
        wait_idle();
        report_test("hit_latency");
    endtask

    task automatic clear_test();
        cache_pkg::cache_addr_t list0 [12];
        cache_pkg::cache_addr_t list1 [12];
        int                     n;
        for (int i = 0; i < 12; i++) begin
            list0[i]     = rand_addr(64);
            list0[i].set = cache_pkg::set_bits'(i);
            list1[i]     = rand_addr(64);
            list1[i].set = cache_pkg::set_bits'(i);
            send_pair(list0[i], list1[i]);
        end
        wait_idle();
        clear_start = 2'b11;
        for (int s = 0; s < set_num; s++) begin
            lru_len[0][s] = 0;
            lru_len[1][s] = 0;
        end
        next_cycle();
        clear_start = 2'b00;
        if (clear_busy !== 2'b11) begin
            $display("mismatch clear_busy: expected %h, got %h", 2'b11, clear_busy);
            errors++;
        end
        n = 0;
        while (clear_busy != 2'b00) begin
            if (n == wait_limit) begin
                abort_run("clear sweep did not finish before the timeout");
            end
            next_cycle();
            n++;
        end
        if (n != set_num) begin
            $display("mismatch clear_busy cycles: expected %h, got %h", set_num, n);
            errors++;
        end
        // the first repeat refills and the second one hits
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 12; i++) begin
                send_pair(list0[i], list1[i]);
            end
            wait_idle();
        end
        report_test("clear");
    endtask

    task automatic contention_test();
        for (int i = 0; i < 100; i++) begin
            send_pair(rand_addr(64), rand_addr(64));
        end
        wait_idle();
        report_test("contention");
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'h4a170f2e));
        reset       = 1'b1;
        req_valid   = 2'b00;
        req         = '0;
        clear_start = 2'b00;
        load_valid  = 1'b0;
        load        = '0;
        cyc         = 0;
        errors      = 0;
        checks      = 0;
        errors_mark = 0;
        checks_mark = 0;
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < set_num; s++) begin
                lru_len[p][s] = 0;
            end
        end

        repeat (16) next_cycle();
        reset = 1'b0;
        // reset starts a sweep in both ports
        if (busy !== 2'b11 || resp_valid !== 2'b00) begin
            $display("mismatch busy/resp_valid after reset: expected %h/%h, got %h/%h",
                     2'b11, 2'b00, busy, resp_valid);
            errors++;
        end

        for (int i = 0; i < word_num; i++) begin
            load_valid   = 1'b1;
            load.addr    = cache_pkg::addr_bits'(i);
            load.data    = $urandom;
            mem_model[i] = load.data;
            next_cycle();
        end
        load_valid = 1'b0;
        wait_idle();

        data_test();
        lru_test();
        hit_latency_test();
        clear_test();
        contention_test();

        $display("responses checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
